//--- soc_periph.f
+incdir+common
common/soc_pkg.sv
common/tgt_if.sv
sram/sram_target.sv
uart/uart_target.sv
hdl/bus_decoder.sv
hdl/response_mux.sv
hdl/soc_periph.sv
sim/soc_periph_assertions.sv
sim/tb_soc_periph.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it, the log decides pass or fail

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert \
  --top-module tb_soc_periph \
  -f soc_periph.f \
  -o tb_soc_periph \
  > build.log 2>&1 || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/tb_soc_periph > sim.log 2>&1
cat sim.log

grep -q "^TB PASSED$" sim.log && echo "Simulation passed" ||
  { echo "Simulation failed, see sim.log"; exit 1; }

//--- sim/tb_soc_periph.sv
// ~~~~~~~~~~~~~~~~~~~~
// Testbench with stimulus table, UART line monitor and summary
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`include "soc_macros.svh"

module tb_soc_periph;

  localparam int max_entries = 40;
  localparam int wait_limit  = 200;  // Cycles allowed per wait
  localparam int uart_div    = 4;

  localparam soc_pkg::addr_t sram_end    = `SRAM_BASE + (32'd1 << `SRAM_ADDR_BITS);
  localparam soc_pkg::addr_t uart_end    = `UART_BASE + (32'd1 << `UART_SPAN_BITS);
  localparam soc_pkg::addr_t uart_div_a  = `UART_BASE + `UART_REG_DIV;
  localparam soc_pkg::addr_t uart_stat_a = `UART_BASE + `UART_REG_STATUS;
  localparam soc_pkg::addr_t uart_tx_a   = `UART_BASE + `UART_REG_TXDATA;

  logic           clk_i;
  logic           i_reset;
  logic           i_req_valid;
  logic           o_req_ready;
  logic           i_req_write;
  soc_pkg::addr_t i_req_addr;
  soc_pkg::size_t i_req_size;
  soc_pkg::data_t i_req_wdata;
  logic           o_rsp_valid;
  logic           i_rsp_ready;
  soc_pkg::data_t o_rsp_rdata;
  logic           o_rsp_err;
  logic           o_uart_tx;

  // Stimulus table, one request per entry
  logic           tbl_write     [max_entries];
  soc_pkg::addr_t tbl_addr      [max_entries];
  soc_pkg::size_t tbl_size      [max_entries];
  soc_pkg::data_t tbl_wdata     [max_entries];
  soc_pkg::data_t tbl_exp_rdata [max_entries];
  logic           tbl_exp_err   [max_entries];
  int             tbl_stall     [max_entries];  // Cycles i_rsp_ready stays low
  int             n_entries;

  soc_pkg::data_t rnd [5];
  integer         seed;
  int             n_checks;
  int             n_errors;
  int             n_tests;
  int             test_errors;
  logic           saw_not_ready;
  int             first_lanes;
  int             first_unmapped;
  int             first_uart;
  int             first_idle;
  int             first_fixup;
  int             first_order;

  soc_periph u_soc_periph (
    .clk_i       (clk_i),
    .i_reset     (i_reset),
    .i_req_valid (i_req_valid),
    .o_req_ready (o_req_ready),
    .i_req_write (i_req_write),
    .i_req_addr  (i_req_addr),
    .i_req_size  (i_req_size),
    .i_req_wdata (i_req_wdata),
    .o_rsp_valid (o_rsp_valid),
    .i_rsp_ready (i_rsp_ready),
    .o_rsp_rdata (o_rsp_rdata),
    .o_rsp_err   (o_rsp_err),
    .o_uart_tx   (o_uart_tx)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  task automatic compare_value(input string name, input int item,
                               input soc_pkg::data_t expected, input soc_pkg::data_t actual);
    n_checks++;
    if (actual !== expected) begin
      $display("** Error at %0t ns: %s (item %0d) expected 0x%0h, got 0x%0h",
               $time, name, item, expected, actual);
      n_errors++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout at %0t ns: %s", $time, what);
    n_errors++;
  endtask

  task automatic add_entry(input logic write, input soc_pkg::addr_t addr,
                           input soc_pkg::size_t size, input soc_pkg::data_t wdata,
                           input soc_pkg::data_t exp_rdata, input logic exp_err,
                           input int stall);
    tbl_write[n_entries]     = write;
    tbl_addr[n_entries]      = addr;
    tbl_size[n_entries]      = size;
    tbl_wdata[n_entries]     = wdata;
    tbl_exp_rdata[n_entries] = exp_rdata;
    tbl_exp_err[n_entries]   = exp_err;
    tbl_stall[n_entries]     = stall;
    n_entries++;
  endtask

  task automatic build_table();
    for (int k = 0; k < 5; k++) begin
      rnd[k] = {$random(seed), $random(seed)};
    end
    n_entries = 0;
    add_entry(1'b1, `SRAM_BASE, 3'd3, rnd[0], '0, 1'b0, 0);
    add_entry(1'b1, `SRAM_BASE + 32'h8, 3'd3, rnd[1], '0, 1'b0, 1);
    add_entry(1'b1, sram_end - 32'h8, 3'd3, rnd[2], '0, 1'b0, 0);
    add_entry(1'b1, `SRAM_BASE + 32'h1230, 3'd3, rnd[3], '0, 1'b0, 2);
    add_entry(1'b0, `SRAM_BASE, 3'd3, '0, rnd[0], 1'b0, 0);
    add_entry(1'b0, `SRAM_BASE + 32'h8, 3'd3, '0, rnd[1], 1'b0, 2);
    add_entry(1'b0, sram_end - 32'h8, 3'd3, '0, rnd[2], 1'b0, 0);
    add_entry(1'b0, `SRAM_BASE + 32'h1230, 3'd3, '0, rnd[3], 1'b0, 1);
    first_lanes = n_entries;
    add_entry(1'b1, `SRAM_BASE + 32'h40, 3'd3, 64'h0011_2233_4455_6677, '0, 1'b0, 0);
    add_entry(1'b1, `SRAM_BASE + 32'h43, 3'd0, 64'hffff_ffff_abff_ffff, '0, 1'b0, 0);
    add_entry(1'b0, `SRAM_BASE + 32'h40, 3'd3, '0, 64'h0011_2233_ab55_6677, 1'b0, 0);
    add_entry(1'b1, `SRAM_BASE + 32'h44, 3'd2, 64'hcafe_f00d_ffff_ffff, '0, 1'b0, 0);
    add_entry(1'b0, `SRAM_BASE + 32'h40, 3'd3, '0, 64'hcafe_f00d_ab55_6677, 1'b0, 0);
    first_unmapped = n_entries;
    add_entry(1'b0, sram_end, 3'd3, '0, '0, 1'b1, 0);
    add_entry(1'b1, uart_end, 3'd2, rnd[4], '0, 1'b1, 1);
    add_entry(1'b0, 32'h8000_0000, 3'd2, '0, '0, 1'b1, 0);
    add_entry(1'b0, `SRAM_BASE + 32'h8, 3'd3, '0, rnd[1], 1'b0, 0);
    first_uart = n_entries;
    add_entry(1'b0, uart_div_a, 3'd2, '0, {`UART_DIV_RESET, `UART_DIV_RESET}, 1'b0, 0);
    add_entry(1'b1, uart_div_a, 3'd2, {32'd0, 32'd4}, '0, 1'b0, 0);
    add_entry(1'b1, uart_tx_a, 3'd2, {56'd0, 8'ha5}, '0, 1'b0, 0);
    add_entry(1'b0, uart_stat_a, 3'd2, '0, {32'd1, 32'd1}, 1'b0, 0);
    add_entry(1'b0, `UART_BASE, 3'd3, '0, {32'd1, 32'd1}, 1'b0, 0);  // Busy, not the divisor
    first_idle = n_entries;
    add_entry(1'b0, uart_stat_a, 3'd2, '0, '0, 1'b0, 0);
    first_fixup = n_entries;
    add_entry(1'b0, `UART_BASE, 3'd3, '0, '0, 1'b0, 0);
    add_entry(1'b0, uart_stat_a, 3'd2, '0, '0, 1'b0, 0);
    add_entry(1'b0, uart_tx_a, 3'd2, '0, {32'h0000_00a5, 32'h0000_00a5}, 1'b0, 0);
    add_entry(1'b0, uart_div_a, 3'd2, '0, {32'd4, 32'd4}, 1'b0, 0);
    first_order = n_entries;
    add_entry(1'b0, `SRAM_BASE + 32'h1230, 3'd3, '0, rnd[3], 1'b0, 6);
    add_entry(1'b1, `SRAM_BASE + 32'h1238, 3'd3, rnd[4], '0, 1'b0, 3);
    add_entry(1'b0, `SRAM_BASE + 32'h1238, 3'd3, '0, rnd[4], 1'b0, 0);
  endtask

  // Holds the request until o_req_ready is seen at a negedge and the next edge takes it
  task automatic send_request(input int idx);
    int waited;
    waited      = 0;
    i_req_valid = 1'b1;
    i_req_write = tbl_write[idx];
    i_req_addr  = tbl_addr[idx];
    i_req_size  = tbl_size[idx];
    i_req_wdata = tbl_wdata[idx];
    @(negedge clk_i);
    while (o_req_ready !== 1'b1 && waited < wait_limit) begin
      saw_not_ready = 1'b1;
      @(negedge clk_i);
      waited++;
    end
    if (o_req_ready !== 1'b1) begin
      report_timeout($sformatf("request %0d was never accepted", idx));
    end
    @(posedge clk_i);
    #5;
    i_req_valid = 1'b0;
  endtask

  task automatic take_response(input int idx);
    int waited;
    waited = 0;
    while (o_rsp_valid !== 1'b1 && waited < wait_limit) begin
      @(negedge clk_i);
      waited++;
    end
    if (o_rsp_valid !== 1'b1) begin
      report_timeout($sformatf("no response for request %0d", idx));
    end else begin
      repeat (tbl_stall[idx]) @(negedge clk_i);
      @(posedge clk_i);
      #5;
      i_rsp_ready = 1'b1;
      @(negedge clk_i);
      compare_value("o_rsp_rdata", idx, tbl_exp_rdata[idx], o_rsp_rdata);
      compare_value("o_rsp_err", idx, {63'd0, tbl_exp_err[idx]}, {63'd0, o_rsp_err});
      @(posedge clk_i);
      #5;
      i_rsp_ready = 1'b0;
    end
  endtask

  task automatic run_range(input int first, input int last);
    fork
      begin
        for (int i = first; i <= last; i++) send_request(i);
      end
      begin
        for (int j = first; j <= last; j++) take_response(j);
      end
    join
  endtask

  // Frame bits are numbered 0 for start, 1 to 8 for data, 9 for stop
  task automatic watch_frame(input logic [7:0] data);
    int waited;
    waited = 0;
    @(negedge clk_i);
    while (o_uart_tx !== 1'b0 && waited < wait_limit) begin
      @(negedge clk_i);
      waited++;
    end
    if (o_uart_tx !== 1'b0) begin
      report_timeout("no start bit on o_uart_tx");
    end else begin
      repeat (uart_div / 2) @(negedge clk_i);  // Middle of the start bit
      compare_value("o_uart_tx", 0, 64'd0, {63'd0, o_uart_tx});
      for (int b = 0; b < 8; b++) begin
        repeat (uart_div) @(negedge clk_i);
        compare_value("o_uart_tx", b + 1, {63'd0, data[b]}, {63'd0, o_uart_tx});
      end
      repeat (uart_div) @(negedge clk_i);
      compare_value("o_uart_tx", 9, 64'd1, {63'd0, o_uart_tx});
    end
  endtask

  task automatic finish_test(input string name);
    n_tests++;
    if (n_errors == test_errors) $display("Test %0d %s: ok", n_tests, name);
    else $display("Test %0d %s: %0d errors", n_tests, name, n_errors - test_errors);
    test_errors = n_errors;
  endtask

  initial begin
    i_reset       = 1'b1;
    i_req_valid   = 1'b0;
    i_req_write   = 1'b0;
    i_req_addr    = '0;
    i_req_size    = '0;
    i_req_wdata   = '0;
    i_rsp_ready   = 1'b0;
    n_checks      = 0;
    n_errors      = 0;
    n_tests       = 0;
    test_errors   = 0;
    saw_not_ready = 1'b0;
    seed          = 97710;
    build_table();
    repeat (3) @(posedge clk_i);
    #5;
    i_reset = 1'b0;
    @(negedge clk_i);
    compare_value("o_rsp_valid", 0, 64'd0, {63'd0, o_rsp_valid});
    compare_value("o_req_ready", 0, 64'd1, {63'd0, o_req_ready});
    compare_value("o_uart_tx", 0, 64'd1, {63'd0, o_uart_tx});
    @(posedge clk_i);
    #5;
    finish_test("reset values");
    run_range(0, first_lanes - 1);
    finish_test("SRAM full word");
    run_range(first_lanes, first_unmapped - 1);
    finish_test("SRAM byte lanes");
    run_range(first_unmapped, first_uart - 1);
    finish_test("unmapped address");
    fork
      watch_frame(8'ha5);
      run_range(first_uart, first_idle - 1);
    join
    repeat (3) @(posedge clk_i);  // Let the stop bit finish
    #5;
    run_range(first_idle, first_fixup - 1);
    finish_test("UART transmit");
    run_range(first_fixup, first_order - 1);
    finish_test("UART size fix-up");
    saw_not_ready = 1'b0;
    run_range(first_order, n_entries - 1);
    n_checks++;
    if (!saw_not_ready) begin
      $display("Error: o_req_ready never fell while responses were stalled");
      n_errors++;
    end
    finish_test("back-pressure and order");
    $display("Tests: %0d, checks: %0d, errors: %0d", n_tests, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- sim/soc_periph_assertions.sv
// ~~~~~~~~~~~~~~~~~~~~
// Response channel and UART line assertions
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module soc_periph_assertions (
  input logic                 clk_i,
  input logic                 i_reset,
  input logic                 i_rsp_valid,
  input logic                 i_rsp_ready,
  input soc_pkg::data_t       i_rsp_rdata,
  input logic                 i_rsp_err,
  input logic                 i_uart_tx,
  input soc_pkg::uart_state_e i_uart_state
);

  // Stalled response holds data and error
  rsp_stable: assert property (@(posedge clk_i) disable iff (i_reset)
    (i_rsp_valid && !i_rsp_ready) |=> ($stable(i_rsp_rdata) && $stable(i_rsp_err)))
    else $error("Response changed while stalled");

  tx_idle_high: assert property (@(posedge clk_i) disable iff (i_reset)
    (i_uart_state == soc_pkg::UART_IDLE) |-> i_uart_tx)
    else $error("UART line low while transmitter idle");

  rsp_clear_after_reset: assert property (@(posedge clk_i)
    i_reset |=> !i_rsp_valid)
    else $error("Response valid in the cycle after reset");

endmodule

bind soc_periph soc_periph_assertions u_assertions (
  .clk_i        (clk_i),
  .i_reset      (i_reset),
  .i_rsp_valid  (o_rsp_valid),
  .i_rsp_ready  (i_rsp_ready),
  .i_rsp_rdata  (o_rsp_rdata),
  .i_rsp_err    (o_rsp_err),
  .i_uart_tx    (o_uart_tx),
  .i_uart_state (u_uart.state)
);

//--- hdl/soc_periph.sv
// ~~~~~~~~~~~~~~~~~~~~
// Peripheral fabric top with SRAM and UART targets
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module soc_periph (
  input  logic           clk_i,
  input  logic           i_reset,

  input  logic           i_req_valid,
  output logic           o_req_ready,
  input  logic           i_req_write,
  input  soc_pkg::addr_t i_req_addr,
  input  soc_pkg::size_t i_req_size,
  input  soc_pkg::data_t i_req_wdata,

  output logic           o_rsp_valid,
  input  logic           i_rsp_ready,
  output soc_pkg::data_t o_rsp_rdata,
  output logic           o_rsp_err,

  output logic           o_uart_tx
);

  tgt_if sram_bus ();
  tgt_if uart_bus ();

  logic slot_free;
  logic err_pulse;

  bus_decoder u_decoder (
    .clk_i       (clk_i),
    .i_reset     (i_reset),
    .i_req_valid (i_req_valid),
    .o_req_ready (o_req_ready),
    .i_req_write (i_req_write),
    .i_req_addr  (i_req_addr),
    .i_req_size  (i_req_size),
    .i_req_wdata (i_req_wdata),
    .i_slot_free (slot_free),
    .sram_bus    (sram_bus.decoder),
    .uart_bus    (uart_bus.decoder),
    .o_err_pulse (err_pulse)
  );

  sram_target u_sram (
    .clk_i (clk_i),
    .bus   (sram_bus.target)
  );

  uart_target u_uart (
    .clk_i     (clk_i),
    .i_reset   (i_reset),
    .bus       (uart_bus.target),
    .o_uart_tx (o_uart_tx)
  );

  // Target replies go to the result stage as plain wires
  response_mux u_result (
    .clk_i        (clk_i),
    .i_reset      (i_reset),
    .i_sram_valid (sram_bus.reply_valid),
    .i_sram_rdata (sram_bus.rdata),
    .i_uart_valid (uart_bus.reply_valid),
    .i_uart_rdata (uart_bus.rdata),
    .i_err_pulse  (err_pulse),
    .o_slot_free  (slot_free),
    .o_rsp_valid  (o_rsp_valid),
    .i_rsp_ready  (i_rsp_ready),
    .o_rsp_rdata  (o_rsp_rdata),
    .o_rsp_err    (o_rsp_err)
  );

endmodule

//--- hdl/response_mux.sv
// ~~~~~~~~~~~~~~~~~~~~
// Response register merging target replies and decode errors
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module response_mux (
  input  logic           clk_i,
  input  logic           i_reset,
  input  logic           i_sram_valid,
  input  soc_pkg::data_t i_sram_rdata,
  input  logic           i_uart_valid,
  input  soc_pkg::data_t i_uart_rdata,
  input  logic           i_err_pulse,
  output logic           o_slot_free,
  output logic           o_rsp_valid,
  input  logic           i_rsp_ready,
  output soc_pkg::data_t o_rsp_rdata,
  output logic           o_rsp_err
);

  logic           tgt_busy;
  logic           load;
  logic           rsp_valid_q;
  logic           rsp_err_q;
  soc_pkg::data_t rsp_rdata_q;

  // A target holds its reply exactly in the cycle its valid is up
  assign tgt_busy = i_sram_valid | i_uart_valid;
  assign load     = tgt_busy | i_err_pulse;

  // Next issue lands here one cycle later, or now for an error
  assign o_slot_free = ~tgt_busy & (~rsp_valid_q | i_rsp_ready);

  always_ff @(posedge clk_i) begin
    if (i_reset) begin
      rsp_valid_q <= 1'b0;
    end else if (load) begin
      rsp_valid_q <= 1'b1;
    end else if (i_rsp_ready) begin
      rsp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      rsp_err_q <= i_err_pulse;
      if (i_sram_valid) begin
        rsp_rdata_q <= i_sram_rdata;
      end else if (i_uart_valid) begin
        rsp_rdata_q <= i_uart_rdata;
      end else begin
        rsp_rdata_q <= '0;  // Decode error
      end
    end
  end

  assign o_rsp_valid = rsp_valid_q;
  assign o_rsp_rdata = rsp_rdata_q;
  assign o_rsp_err   = rsp_err_q;

endmodule

//--- hdl/bus_decoder.sv
// ~~~~~~~~~~~~~~~~~~~~
// Request register, address decode and issue control
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`include "soc_macros.svh"

module bus_decoder (
  input  logic           clk_i,
  input  logic           i_reset,
  input  logic           i_req_valid,
  output logic           o_req_ready,
  input  logic           i_req_write,
  input  soc_pkg::addr_t i_req_addr,
  input  soc_pkg::size_t i_req_size,
  input  soc_pkg::data_t i_req_wdata,
  input  logic           i_slot_free,
  tgt_if.decoder         sram_bus,
  tgt_if.decoder         uart_bus,
  output logic           o_err_pulse
);

  localparam soc_pkg::addr_t sram_base = `SRAM_BASE;
  localparam soc_pkg::addr_t uart_base = `UART_BASE;

  logic                req_full;
  logic                req_write;
  soc_pkg::addr_t      req_addr;
  soc_pkg::size_t      req_size;
  soc_pkg::data_t      req_wdata;
  logic                accept;
  logic                can_issue;
  logic                hit_sram;
  logic                hit_uart;
  logic [7:0]          lane_mask;
  soc_pkg::sram_addr_t sram_idx;
  soc_pkg::addr_t      uart_off;

  assign can_issue   = req_full & i_slot_free;
  assign o_req_ready = ~req_full | can_issue;  // Refill in the cycle the slot drains
  assign accept      = i_req_valid & o_req_ready;

  always_ff @(posedge clk_i) begin
    if (i_reset) begin
      req_full <= 1'b0;
    end else if (accept) begin
      req_full <= 1'b1;
    end else if (can_issue) begin
      req_full <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_write <= i_req_write;
      req_addr  <= i_req_addr;
      req_size  <= i_req_size;
      req_wdata <= i_req_wdata;
    end
  end

  assign hit_sram = req_addr[31:`SRAM_ADDR_BITS] == sram_base[31:`SRAM_ADDR_BITS];
  assign hit_uart = req_addr[31:`UART_SPAN_BITS] == uart_base[31:`UART_SPAN_BITS];

  always_comb begin
    case (req_size)
      3'd0:    lane_mask = 8'h01;
      3'd1:    lane_mask = 8'h03;
      3'd2:    lane_mask = 8'h0f;
      default: lane_mask = 8'hff;
    endcase
  end

  assign sram_idx = req_addr[`SRAM_ADDR_BITS-1:3];

  assign sram_bus.issue = can_issue & hit_sram;
  assign sram_bus.write = req_write;
  assign sram_bus.addr  = soc_pkg::addr_t'(sram_idx);
  assign sram_bus.wdata = req_wdata;
  assign sram_bus.be    = lane_mask << req_addr[2:0];

  // A 64-bit access to the 32-bit UART reads the upper word only
  assign uart_off = soc_pkg::addr_t'(req_addr[`UART_SPAN_BITS-1:0]) +
                    ((req_size == 3'd3) ? 32'd4 : 32'd0);

  assign uart_bus.issue = can_issue & hit_uart;
  assign uart_bus.write = req_write;
  assign uart_bus.addr  = uart_off;
  assign uart_bus.wdata = req_wdata;
  assign uart_bus.be    = uart_off[2] ? 8'hf0 : 8'h0f;

  assign o_err_pulse = can_issue & ~hit_sram & ~hit_uart;  // Unmapped

endmodule

//--- uart/uart_target.sv
// ~~~~~~~~~~~~~~~~~~~~
// UART register block and 8N1 transmitter
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`include "soc_macros.svh"

module uart_target (
  input  logic  clk_i,
  input  logic  i_reset,
  tgt_if.target bus,
  output logic  o_uart_tx
);

  soc_pkg::uart_state_e state;
  soc_pkg::word_t       divisor;
  soc_pkg::word_t       cyc_cnt;
  soc_pkg::word_t       wr_word;
  soc_pkg::word_t       rd_word;
  soc_pkg::data_t       rdata_q;
  logic [7:0]           last_byte;
  logic [7:0]           shift;
  logic [2:0]           bit_cnt;
  logic                 busy;
  logic                 bit_done;
  logic                 tx_start;
  logic                 tx_q;
  logic                 reply_q;

  assign busy     = state != soc_pkg::UART_IDLE;
  assign bit_done = cyc_cnt == divisor - 32'd1;
  assign wr_word  = bus.be[4] ? bus.wdata[63:32] : bus.wdata[31:0];
  assign tx_start = bus.issue & bus.write & (bus.addr == `UART_REG_TXDATA) & ~busy;

  always_ff @(posedge clk_i) begin
    if (i_reset) begin
      divisor   <= `UART_DIV_RESET;
      last_byte <= 8'h00;
    end else if (bus.issue && bus.write) begin
      if (bus.addr == `UART_REG_DIV) divisor <= wr_word;
      if (tx_start) last_byte <= wr_word[7:0];  // Writes while busy are dropped
    end
  end

  always_ff @(posedge clk_i) begin
    if (i_reset) begin
      state   <= soc_pkg::UART_IDLE;
      tx_q    <= 1'b1;
      cyc_cnt <= '0;
      bit_cnt <= '0;
    end else begin
      cyc_cnt <= (bit_done || !busy) ? '0 : cyc_cnt + 32'd1;
      case (state)
        soc_pkg::UART_IDLE: begin
          if (tx_start) begin
            state <= soc_pkg::UART_START;
            tx_q  <= 1'b0;
            shift <= wr_word[7:0];
          end
        end
        soc_pkg::UART_START: begin
          if (bit_done) begin
            state   <= soc_pkg::UART_DATA;
            tx_q    <= shift[0];  // LSB first
            shift   <= shift >> 1;
            bit_cnt <= '0;
          end
        end
        soc_pkg::UART_DATA: begin
          if (bit_done) begin
            if (bit_cnt == 3'd7) begin
              state <= soc_pkg::UART_STOP;
              tx_q  <= 1'b1;
            end else begin
              tx_q    <= shift[0];
              shift   <= shift >> 1;
              bit_cnt <= bit_cnt + 3'd1;
            end
          end
        end
        default: begin
          if (bit_done) state <= soc_pkg::UART_IDLE;
        end
      endcase
    end
  end

  always_comb begin
    case (bus.addr)
      `UART_REG_DIV:    rd_word = divisor;
      `UART_REG_STATUS: rd_word = {31'b0, busy};
      `UART_REG_TXDATA: rd_word = {24'b0, last_byte};
      default:          rd_word = '0;
    endcase
  end

  // 32-bit value shows up on both halves
  always_ff @(posedge clk_i) begin
    if (bus.issue) rdata_q <= bus.write ? '0 : {rd_word, rd_word};
  end

  always_ff @(posedge clk_i) begin
    if (i_reset) reply_q <= 1'b0;
    else         reply_q <= bus.issue;
  end

  assign bus.reply_valid = reply_q;
  assign bus.rdata       = rdata_q;
  assign o_uart_tx       = tx_q;

endmodule

//--- sram/sram_target.sv
// ~~~~~~~~~~~~~~~~~~~~
// Local 64-bit SRAM with byte-lane writes
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module sram_target (
  input  logic   clk_i,
  tgt_if.target  bus
);

  localparam int unsigned depth = 2 ** $bits(soc_pkg::sram_addr_t);

  soc_pkg::data_t      mem [0:depth-1];
  soc_pkg::sram_addr_t word_idx;
  soc_pkg::data_t      rdata_q;
  logic                reply_q;

  assign word_idx = bus.addr[$bits(soc_pkg::sram_addr_t)-1:0];

  // Only enabled lanes are written
  always_ff @(posedge clk_i) begin
    if (bus.issue && bus.write) begin
      for (int lane = 0; lane < 8; lane++) begin
        if (bus.be[lane]) begin
          mem[word_idx][8*lane +: 8] <= bus.wdata[8*lane +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus.issue) begin
      rdata_q <= bus.write ? '0 : mem[word_idx];  // Writes answer with zero
    end
  end

  // Reply follows issue by one cycle
  always_ff @(posedge clk_i) begin
    reply_q <= bus.issue;
  end

  assign bus.reply_valid = reply_q;
  assign bus.rdata       = rdata_q;

endmodule

//--- common/tgt_if.sv
// ~~~~~~~~~~~~~~~~~~~~
// Decoder to target access channel
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

interface tgt_if;

  logic           issue;        // One-cycle pulse
  logic           write;
  soc_pkg::addr_t addr;         // Word index for SRAM, register offset for UART
  soc_pkg::data_t wdata;        // Lane aligned
  logic [7:0]     be;
  logic           reply_valid;  // One cycle after issue
  soc_pkg::data_t rdata;

  modport decoder (
    output issue, write, addr, wdata, be,
    input  reply_valid, rdata
  );

  modport target (
    input  issue, write, addr, wdata, be,
    output reply_valid, rdata
  );

endinterface

//--- common/soc_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// Bus vector types and UART transmitter states
// ~~~~~~~~~~~~~~~~~~~~

package soc_pkg;

  // Requester side
  typedef logic [31:0] addr_t;  // Byte address
  typedef logic [63:0] data_t;  // Full bus width
  typedef logic [2:0]  size_t;  // log2 of the byte count

  // UART registers are 32 bits wide
  typedef logic [31:0] word_t;

  // SRAM word index, byte address without the 3 lane bits
  typedef logic [13:0] sram_addr_t;

  // 8N1 transmitter
  typedef enum logic [1:0] {
    UART_IDLE,
    UART_START,
    UART_DATA,
    UART_STOP
  } uart_state_e;

endpackage

//--- common/soc_macros.svh
// ~~~~~~~~~~~~~~~~~~~~
// Address map, UART register offsets and defaults
// ~~~~~~~~~~~~~~~~~~~~

`ifndef SOC_MACROS_SVH
`define SOC_MACROS_SVH

// Regions
`define SRAM_BASE       32'h0000_0000
`define SRAM_ADDR_BITS  17
`define UART_BASE       32'h1000_0000
`define UART_SPAN_BITS  4

// UART register offsets
`define UART_REG_DIV     32'h0000_0000  // Clock cycles per bit
`define UART_REG_STATUS  32'h0000_0004  // Bit 0 is busy
`define UART_REG_TXDATA  32'h0000_0008

`define UART_DIV_RESET   32'd16

`endif
